/* src/bridge_pkg.sv */
package bridge_pkg;

  localparam int AXI_ADDR_W  = 64;
  localparam int AXI_DATA_W  = 128;
  localparam int AXI_STRB_W  = AXI_DATA_W / 8;
  localparam int AXI_ID_W    = 4;
  localparam int HOST_ADDR_W = 15;
  localparam int HOST_DATA_W = 32;
  localparam int STAGE_W     = 256;

  localparam logic [AXI_ID_W-1:0] AWID_FIXED = 4'd1;
  localparam logic [AXI_ID_W-1:0] ARID_FIXED = 4'd2;
  localparam logic [1:0]          BURST_INCR = 2'd1;

  // host byte addresses
  typedef enum logic [HOST_ADDR_W-1:0] {
    REG_DATA0       = 15'h000,
    REG_DATA1       = 15'h004,
    REG_DATA2       = 15'h008,
    REG_DATA3       = 15'h00c,
    REG_DATA4       = 15'h010,
    REG_DATA5       = 15'h014,
    REG_DATA6       = 15'h018,
    REG_DATA7       = 15'h01c,
    REG_PUSH_AW     = 15'h020,
    REG_PUSH_W      = 15'h030,
    REG_PUSH_AR     = 15'h040,
    REG_B_STATUS    = 15'h050,
    REG_B_POP       = 15'h054,
    REG_R_STATUS    = 15'h060,
    REG_R_POP       = 15'h064,
    REG_FAR_RST_ON  = 15'h0c0,
    REG_FAR_RST_OFF = 15'h0c4
  } host_reg_e;

  typedef struct packed {
    logic [2:0]            size;
    logic [AXI_ADDR_W-1:0] addr;
  } aw_entry_t; // also used for AR

  typedef struct packed {
    logic [AXI_STRB_W-1:0] strb;
    logic [AXI_DATA_W-1:0] data;
  } w_entry_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0] id;
    logic [1:0]          resp;
  } b_entry_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0]   id;
    logic [1:0]            resp;
    logic [AXI_DATA_W-1:0] data;
  } r_entry_t;

endpackage

/* src/stage_if.sv */
`timescale 1ns/1ps

interface stage_if import bridge_pkg::*; ();

  logic [STAGE_W-1:0] stage;   // staged request bits
  logic               push_aw;
  logic               push_w;
  logic               push_ar;
  logic               pop_b;
  logic               pop_r;

  b_entry_t           b_head;
  r_entry_t           r_head;
  logic               b_avail;
  logic               r_avail;

  modport regs (
    output stage,
    output push_aw,
    output push_w,
    output push_ar,
    output pop_b,
    output pop_r,
    input  b_head,
    input  r_head,
    input  b_avail,
    input  r_avail
  );

  modport queues (
    input  stage,
    input  push_aw,
    input  push_w,
    input  push_ar,
    input  pop_b,
    input  pop_r,
    output b_head,
    output r_head,
    output b_avail,
    output r_avail
  );

endinterface

/* src/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
  parameter int DATA_W = 8,
  parameter int DEPTH  = 16
) (
  input  logic              clk,
  input  logic              rstn,
  input  logic              wvalid,
  input  logic [DATA_W-1:0] wdata,
  output logic              wready,
  output logic              rvalid,
  output logic [DATA_W-1:0] rdata,
  input  logic              rready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [DATA_W-1:0] mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              do_wr;
  logic              do_rd;

  assign wready = (count != CNT_W'(DEPTH));
  assign rvalid = (count != '0);
  assign do_wr  = wvalid && wready;
  assign do_rd  = rvalid && rready;
  assign rdata  = mem[rd_ptr]; // head shown while valid

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wdata;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* src/host_regs.sv */
`timescale 1ns/1ps

module host_regs import bridge_pkg::*; (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   host_en,
  input  logic [3:0]             host_we,
  input  logic [HOST_ADDR_W-1:0] host_addr,
  input  logic [HOST_DATA_W-1:0] host_din,
  output logic [HOST_DATA_W-1:0] host_dout,
  output logic                   far_rstn,
  stage_if.regs                  stg
);

  localparam int WORD_SEL_W = $clog2(STAGE_W / HOST_DATA_W);

  host_reg_e             op;
  logic                  wr_acc;
  logic                  rd_acc;
  logic [WORD_SEL_W-1:0] word_sel;
  logic [STAGE_W-1:0]    stage_q;
  logic                  push_aw_q;
  logic                  push_w_q;
  logic                  push_ar_q;
  logic                  pop_b_q;
  logic                  pop_r_q;
  logic                  far_sw;

  assign op       = host_reg_e'(host_addr);
  assign wr_acc   = host_en && (host_we != '0); // any lane counts as a write
  assign rd_acc   = host_en && (host_we == '0);
  assign word_sel = host_addr[WORD_SEL_W+1:2];

  assign stg.stage   = stage_q;
  assign stg.push_aw = push_aw_q;
  assign stg.push_w  = push_w_q;
  assign stg.push_ar = push_ar_q;
  assign stg.pop_b   = pop_b_q;
  assign stg.pop_r   = pop_r_q;

  // staging words, and queue heads landing on a pop
  always_ff @(posedge clk) begin
    if (wr_acc) begin
      case (op)
        REG_DATA0,
        REG_DATA1,
        REG_DATA2,
        REG_DATA3,
        REG_DATA4,
        REG_DATA5,
        REG_DATA6,
        REG_DATA7: begin
          stage_q[word_sel*HOST_DATA_W +: HOST_DATA_W] <= host_din;
        end
        REG_B_POP: begin
          if (stg.b_avail) begin
            stage_q <= STAGE_W'(stg.b_head); // zero-extended
          end
        end
        REG_R_POP: begin
          if (stg.r_avail) begin
            stage_q <= STAGE_W'(stg.r_head);
          end
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      push_aw_q <= 1'b0;
      push_w_q  <= 1'b0;
      push_ar_q <= 1'b0;
      pop_b_q   <= 1'b0;
      pop_r_q   <= 1'b0;
      far_sw    <= 1'b1;
      far_rstn  <= 1'b0;
      host_dout <= '0;
    end else begin
      push_aw_q <= 1'b0; // strobes last one cycle
      push_w_q  <= 1'b0;
      push_ar_q <= 1'b0;
      pop_b_q   <= 1'b0;
      pop_r_q   <= 1'b0;
      far_rstn  <= far_sw;

      if (wr_acc) begin
        case (op)
          REG_PUSH_AW:     push_aw_q <= 1'b1;
          REG_PUSH_W:      push_w_q  <= 1'b1;
          REG_PUSH_AR:     push_ar_q <= 1'b1;
          REG_B_POP:       pop_b_q   <= stg.b_avail;
          REG_R_POP:       pop_r_q   <= stg.r_avail;
          REG_FAR_RST_ON:  far_sw    <= 1'b0;
          REG_FAR_RST_OFF: far_sw    <= 1'b1;
          default: ;
        endcase
      end

      if (rd_acc) begin
        case (op)
          REG_DATA0,
          REG_DATA1,
          REG_DATA2,
          REG_DATA3,
          REG_DATA4,
          REG_DATA5,
          REG_DATA6,
          REG_DATA7: begin
            host_dout <= stage_q[word_sel*HOST_DATA_W +: HOST_DATA_W];
          end
          REG_B_STATUS: host_dout <= HOST_DATA_W'(stg.b_avail);
          REG_R_STATUS: host_dout <= HOST_DATA_W'(stg.r_avail);
          default: ; // keep last value
        endcase
      end
    end
  end

endmodule

/* src/channel_queues.sv */
`timescale 1ns/1ps

module channel_queues import bridge_pkg::*; #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic                  clk,
  input  logic                  rstn,
  output logic [AXI_ADDR_W-1:0] awaddr,
  output logic [1:0]            awburst,
  output logic [3:0]            awcache,
  output logic [AXI_ID_W-1:0]   awid,
  output logic [7:0]            awlen,
  output logic                  awlock,
  output logic [2:0]            awprot,
  output logic [3:0]            awqos,
  input  logic                  awready,
  output logic [2:0]            awsize,
  output logic                  awvalid,
  output logic [AXI_DATA_W-1:0] wdata,
  output logic                  wlast,
  input  logic                  wready,
  output logic [AXI_STRB_W-1:0] wstrb,
  output logic                  wvalid,
  output logic [AXI_ADDR_W-1:0] araddr,
  output logic [1:0]            arburst,
  output logic [3:0]            arcache,
  output logic [AXI_ID_W-1:0]   arid,
  output logic [7:0]            arlen,
  output logic                  arlock,
  output logic [2:0]            arprot,
  output logic [3:0]            arqos,
  input  logic                  arready,
  output logic [2:0]            arsize,
  output logic                  arvalid,
  input  logic [AXI_ID_W-1:0]   bid,
  output logic                  bready,
  input  logic [1:0]            bresp,
  input  logic                  bvalid,
  input  logic [AXI_DATA_W-1:0] rdata,
  input  logic [AXI_ID_W-1:0]   rid,
  output logic                  rready,
  input  logic [1:0]            rresp,
  input  logic                  rvalid,
  stage_if.queues               stg
);

  localparam int AW_W = $bits(aw_entry_t);
  localparam int W_W  = $bits(w_entry_t);
  localparam int B_W  = $bits(b_entry_t);
  localparam int R_W  = $bits(r_entry_t);

  aw_entry_t aw_head;
  w_entry_t  w_head;
  aw_entry_t ar_head;
  b_entry_t  b_in;
  r_entry_t  r_in;

  // request pushes into a full fifo are dropped
  sync_fifo #(.DATA_W(AW_W), .DEPTH(FIFO_DEPTH)) i_aw_fifo (
    .clk(clk), .rstn(rstn),
    .wvalid(stg.push_aw), .wdata(stg.stage[AW_W-1:0]), .wready(),
    .rvalid(awvalid), .rdata(aw_head), .rready(awready)
  );

  sync_fifo #(.DATA_W(W_W), .DEPTH(FIFO_DEPTH)) i_w_fifo (
    .clk(clk), .rstn(rstn),
    .wvalid(stg.push_w), .wdata(stg.stage[W_W-1:0]), .wready(),
    .rvalid(wvalid), .rdata(w_head), .rready(wready)
  );

  sync_fifo #(.DATA_W(AW_W), .DEPTH(FIFO_DEPTH)) i_ar_fifo (
    .clk(clk), .rstn(rstn),
    .wvalid(stg.push_ar), .wdata(stg.stage[AW_W-1:0]), .wready(),
    .rvalid(arvalid), .rdata(ar_head), .rready(arready)
  );

  assign b_in = '{id: bid, resp: bresp};
  assign r_in = '{id: rid, resp: rresp, data: rdata};

  // responses drained by host pops
  sync_fifo #(.DATA_W(B_W), .DEPTH(FIFO_DEPTH)) i_b_fifo (
    .clk(clk), .rstn(rstn),
    .wvalid(bvalid), .wdata(b_in), .wready(bready),
    .rvalid(stg.b_avail), .rdata(stg.b_head), .rready(stg.pop_b)
  );

  sync_fifo #(.DATA_W(R_W), .DEPTH(FIFO_DEPTH)) i_r_fifo (
    .clk(clk), .rstn(rstn),
    .wvalid(rvalid), .wdata(r_in), .wready(rready),
    .rvalid(stg.r_avail), .rdata(stg.r_head), .rready(stg.pop_r)
  );

  assign awaddr  = aw_head.addr;
  assign awsize  = aw_head.size;
  assign awid    = AWID_FIXED;
  assign awburst = BURST_INCR;
  assign awlen   = 8'd0; // single beat
  assign awcache = 4'd0;
  assign awlock  = 1'b0;
  assign awprot  = 3'd0;
  assign awqos   = 4'd0;

  assign wdata = w_head.data;
  assign wstrb = w_head.strb;
  assign wlast = 1'b1;

  assign araddr  = ar_head.addr;
  assign arsize  = ar_head.size;
  assign arid    = ARID_FIXED;
  assign arburst = BURST_INCR;
  assign arlen   = 8'd0;
  assign arcache = 4'd0;
  assign arlock  = 1'b0;
  assign arprot  = 3'd0;
  assign arqos   = 4'd0;

endmodule

/* src/host_axi_bridge.sv */
`timescale 1ns/1ps

module host_axi_bridge import bridge_pkg::*; #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   host_en,
  input  logic [3:0]             host_we,
  input  logic [HOST_ADDR_W-1:0] host_addr,
  input  logic [HOST_DATA_W-1:0] host_din,
  output logic [HOST_DATA_W-1:0] host_dout,
  output logic                   far_rstn,
  output logic [AXI_ADDR_W-1:0]  awaddr,
  output logic [1:0]             awburst,
  output logic [3:0]             awcache,
  output logic [AXI_ID_W-1:0]    awid,
  output logic [7:0]             awlen,
  output logic                   awlock,
  output logic [2:0]             awprot,
  output logic [3:0]             awqos,
  input  logic                   awready,
  output logic [2:0]             awsize,
  output logic                   awvalid,
  output logic [AXI_DATA_W-1:0]  wdata,
  output logic                   wlast,
  input  logic                   wready,
  output logic [AXI_STRB_W-1:0]  wstrb,
  output logic                   wvalid,
  output logic [AXI_ADDR_W-1:0]  araddr,
  output logic [1:0]             arburst,
  output logic [3:0]             arcache,
  output logic [AXI_ID_W-1:0]    arid,
  output logic [7:0]             arlen,
  output logic                   arlock,
  output logic [2:0]             arprot,
  output logic [3:0]             arqos,
  input  logic                   arready,
  output logic [2:0]             arsize,
  output logic                   arvalid,
  input  logic [AXI_ID_W-1:0]    bid,
  output logic                   bready,
  input  logic [1:0]             bresp,
  input  logic                   bvalid,
  input  logic [AXI_DATA_W-1:0]  rdata,
  input  logic [AXI_ID_W-1:0]    rid,
  output logic                   rready,
  input  logic [1:0]             rresp,
  input  logic                   rvalid
);

  stage_if i_stage ();

  host_regs i_regs (
    .clk       (clk),
    .rstn      (rstn),
    .host_en   (host_en),
    .host_we   (host_we),
    .host_addr (host_addr),
    .host_din  (host_din),
    .host_dout (host_dout),
    .far_rstn  (far_rstn),
    .stg       (i_stage.regs)
  );

  channel_queues #(.FIFO_DEPTH(FIFO_DEPTH)) i_queues (
    .clk(clk), .rstn(rstn),
    .awaddr(awaddr), .awburst(awburst), .awcache(awcache), .awid(awid),
    .awlen(awlen), .awlock(awlock), .awprot(awprot), .awqos(awqos),
    .awready(awready), .awsize(awsize), .awvalid(awvalid),
    .wdata(wdata), .wlast(wlast), .wready(wready), .wstrb(wstrb), .wvalid(wvalid),
    .araddr(araddr), .arburst(arburst), .arcache(arcache), .arid(arid),
    .arlen(arlen), .arlock(arlock), .arprot(arprot), .arqos(arqos),
    .arready(arready), .arsize(arsize), .arvalid(arvalid),
    .bid(bid), .bready(bready), .bresp(bresp), .bvalid(bvalid),
    .rdata(rdata), .rid(rid), .rready(rready), .rresp(rresp), .rvalid(rvalid),
    .stg(i_stage.queues)
  );

endmodule

/* include/bridge_tb_tasks.svh */
`ifndef BRIDGE_TB_TASKS_SVH
`define BRIDGE_TB_TASKS_SVH

int unsigned errors = 0;
logic [31:0] lfsr   = 32'h40ee_b693;

// galois form, taps 32,22,2,1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  logic [31:0] n;
  n = s >> 1;
  if (s[0]) begin
    n = n ^ 32'h8020_0003;
  end
  return n;
endfunction

// one lfsr step per bit
task automatic rand_bits(input int n, output logic [bridge_pkg::AXI_DATA_W-1:0] v);
  v = '0;
  for (int i = 0; i < n; i++) begin
    lfsr = lfsr_step(lfsr);
    v    = {v[bridge_pkg::AXI_DATA_W-2:0], lfsr[0]};
  end
endtask

task automatic host_write(input bridge_pkg::host_reg_e addr, input logic [31:0] data);
  @(posedge clk);
  #10;
  host_en   = 1'b1;
  host_we   = 4'hf;
  host_addr = addr;
  host_din  = data;
  @(posedge clk); // access edge
  #10;
  host_en = 1'b0;
  host_we = 4'h0;
  @(posedge clk);
endtask

task automatic host_read(input bridge_pkg::host_reg_e addr, output logic [31:0] data);
  @(posedge clk);
  #10;
  host_en   = 1'b1;
  host_we   = 4'h0;
  host_addr = addr;
  @(posedge clk);
  #10;
  host_en = 1'b0;
  data    = host_dout; // registered at the access edge
  @(posedge clk);
endtask

task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
  if (got !== exp) begin
    $display("Fail %s: got %h expected %h", name, got, exp);
    errors++;
  end
endtask

task automatic check_aw(input string name, input bridge_pkg::aw_entry_t got,
                        input bridge_pkg::aw_entry_t exp);
  if (got !== exp) begin
    $display("Fail %s: got %h expected %h", name, got, exp);
    errors++;
  end
endtask

task automatic check_w(input string name, input bridge_pkg::w_entry_t got,
                       input bridge_pkg::w_entry_t exp);
  if (got !== exp) begin
    $display("Fail %s: got %h expected %h", name, got, exp);
    errors++;
  end
endtask

task automatic check_b(input string name, input bridge_pkg::b_entry_t got,
                       input bridge_pkg::b_entry_t exp);
  if (got !== exp) begin
    $display("Fail %s: got %h expected %h", name, got, exp);
    errors++;
  end
endtask

task automatic check_r(input string name, input bridge_pkg::r_entry_t got,
                       input bridge_pkg::r_entry_t exp);
  if (got !== exp) begin
    $display("Fail %s: got %h expected %h", name, got, exp);
    errors++;
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("Fail %s: got %h expected %h", name, got, exp);
    errors++;
  end
endtask

`endif

/* sim/tb_host_axi_bridge.sv */
`timescale 1ns/1ps

module tb_host_axi_bridge import bridge_pkg::*;;

  localparam int MAX_CYCLES = 2000; // well above the length of all tests

  logic                   clk;
  logic                   rstn;
  logic                   host_en;
  logic [3:0]             host_we;
  logic [HOST_ADDR_W-1:0] host_addr;
  logic [HOST_DATA_W-1:0] host_din;
  logic [HOST_DATA_W-1:0] host_dout;
  logic                   far_rstn;
  logic [AXI_ADDR_W-1:0]  awaddr;
  logic [1:0]             awburst;
  logic [3:0]             awcache;
  logic [AXI_ID_W-1:0]    awid;
  logic [7:0]             awlen;
  logic                   awlock;
  logic [2:0]             awprot;
  logic [3:0]             awqos;
  logic                   awready;
  logic [2:0]             awsize;
  logic                   awvalid;
  logic [AXI_DATA_W-1:0]  wdata;
  logic                   wlast;
  logic                   wready;
  logic [AXI_STRB_W-1:0]  wstrb;
  logic                   wvalid;
  logic [AXI_ADDR_W-1:0]  araddr;
  logic [1:0]             arburst;
  logic [3:0]             arcache;
  logic [AXI_ID_W-1:0]    arid;
  logic [7:0]             arlen;
  logic                   arlock;
  logic [2:0]             arprot;
  logic [3:0]             arqos;
  logic                   arready;
  logic [2:0]             arsize;
  logic                   arvalid;
  logic [AXI_ID_W-1:0]    bid;
  logic                   bready;
  logic [1:0]             bresp;
  logic                   bvalid;
  logic [AXI_DATA_W-1:0]  rdata;
  logic [AXI_ID_W-1:0]    rid;
  logic                   rready;
  logic [1:0]             rresp;
  logic                   rvalid;
  int unsigned            cycles = 0;

  `include "bridge_tb_tasks.svh"

  host_axi_bridge #(.FIFO_DEPTH(16)) i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Errors: %0d", errors);
      $display("Done: errors found");
      $finish;
    end
  end

  function automatic logic valid_of(input int ch);
    case (ch)
      0:       return awvalid;
      1:       return wvalid;
      default: return arvalid;
    endcase
  endfunction

  // polls a request valid 5 ns after each edge
  task automatic wait_for_valid(input int ch, input string name);
    int n;
    n = 0;
    #5;
    while (!valid_of(ch) && n < 20) begin
      @(posedge clk);
      #5;
      n++;
    end
    if (!valid_of(ch)) begin
      $display("%s never went high after the push", name);
      errors++;
    end
  endtask

  task automatic write_stage(input logic [STAGE_W-1:0] bits, input int words);
    for (int i = 0; i < words; i++) begin
      host_write(host_reg_e'(HOST_ADDR_W'(4 * i)), bits[32*i +: 32]);
    end
  endtask

  task automatic send_b_response(input b_entry_t e);
    @(posedge clk);
    #10;
    bid    = e.id;
    bresp  = e.resp;
    bvalid = 1'b1;
    @(posedge clk);
    #10;
    bvalid = 1'b0;
  endtask

  task automatic send_r_response(input r_entry_t e);
    @(posedge clk);
    #10;
    rid    = e.id;
    rresp  = e.resp;
    rdata  = e.data;
    rvalid = 1'b1;
    @(posedge clk);
    #10;
    rvalid = 1'b0;
  endtask

  task automatic check_reset_state();
    @(posedge clk);
    #5;
    check_bit("far_rstn", far_rstn, 1'b1); // one cycle after reset ends
    check_bit("awvalid", awvalid, 1'b0);
    check_bit("wvalid", wvalid, 1'b0);
    check_bit("arvalid", arvalid, 1'b0);
    check_bit("bready", bready, 1'b1);
    check_bit("rready", rready, 1'b1);
  endtask

  task automatic test_stage_readback();
    logic [AXI_DATA_W-1:0]  v;
    logic [HOST_DATA_W-1:0] exp_w [8];
    logic [HOST_DATA_W-1:0] d;
    for (int i = 0; i < 8; i++) begin
      rand_bits(32, v);
      exp_w[i] = v[31:0];
      host_write(host_reg_e'(HOST_ADDR_W'(4 * i)), exp_w[i]);
    end
    for (int i = 0; i < 8; i++) begin
      host_read(host_reg_e'(HOST_ADDR_W'(4 * i)), d);
      check_word($sformatf("host_dout word %0d", i), d, exp_w[i]);
    end
  endtask

  task automatic test_write_request();
    logic [AXI_DATA_W-1:0] v;
    aw_entry_t             exp_aw;
    w_entry_t              exp_w;
    rand_bits(64, v);
    exp_aw.addr = v[63:0];
    rand_bits(3, v);
    exp_aw.size = v[2:0];
    write_stage(STAGE_W'(exp_aw), 3);
    host_write(REG_PUSH_AW, 32'h0);
    wait_for_valid(0, "awvalid");
    check_aw("aw fields", '{size: awsize, addr: awaddr}, exp_aw);
    check_word("awid", 32'(awid), 32'h1);
    check_word("awburst", 32'(awburst), 32'h1);
    check_word("awlen", 32'(awlen), 32'h0);
    check_word("awcache", 32'(awcache), 32'h0);
    check_bit("awlock", awlock, 1'b0);
    check_word("awprot", 32'(awprot), 32'h0);
    check_word("awqos", 32'(awqos), 32'h0);
    @(posedge clk); // handshake with awready high
    #5;
    check_bit("awvalid", awvalid, 1'b0);

    rand_bits(128, v);
    exp_w.data = v;
    rand_bits(16, v);
    exp_w.strb = v[15:0];
    write_stage(STAGE_W'(exp_w), 5);
    host_write(REG_PUSH_W, 32'h0);
    wait_for_valid(1, "wvalid");
    check_w("w fields", '{strb: wstrb, data: wdata}, exp_w);
    check_bit("wlast", wlast, 1'b1);
    @(posedge clk);
    #5;
    check_bit("wvalid", wvalid, 1'b0);
  endtask

  task automatic test_read_backpressure();
    logic [AXI_DATA_W-1:0] v;
    aw_entry_t             e1;
    aw_entry_t             e2;
    @(posedge clk);
    #10;
    arready = 1'b0;
    rand_bits(64, v);
    e1.addr = v[63:0];
    rand_bits(3, v);
    e1.size = v[2:0];
    rand_bits(64, v);
    e2.addr = v[63:0];
    rand_bits(3, v);
    e2.size = v[2:0];
    write_stage(STAGE_W'(e1), 3);
    host_write(REG_PUSH_AR, 32'h0);
    wait_for_valid(2, "arvalid");
    check_aw("ar head first", '{size: arsize, addr: araddr}, e1);
    write_stage(STAGE_W'(e2), 3);
    host_write(REG_PUSH_AR, 32'h0);
    #5;
    check_bit("arvalid held", arvalid, 1'b1);
    check_aw("ar head held", '{size: arsize, addr: araddr}, e1);
    @(posedge clk);
    #10;
    arready = 1'b1;
    @(posedge clk); // first entry leaves
    #5;
    check_bit("arvalid second", arvalid, 1'b1);
    check_aw("ar head second", '{size: arsize, addr: araddr}, e2);
    check_word("arid", 32'(arid), 32'h2);
    check_word("arburst", 32'(arburst), 32'h1);
    check_word("arlen", 32'(arlen), 32'h0);
    check_word("arcache", 32'(arcache), 32'h0);
    check_bit("arlock", arlock, 1'b0);
    check_word("arprot", 32'(arprot), 32'h0);
    check_word("arqos", 32'(arqos), 32'h0);
    @(posedge clk);
    #5;
    check_bit("arvalid", arvalid, 1'b0);
  endtask

  task automatic test_write_response();
    logic [AXI_DATA_W-1:0]  v;
    logic [HOST_DATA_W-1:0] d;
    b_entry_t               exp_b;
    b_entry_t               got_b;
    rand_bits(4, v);
    exp_b.id = v[3:0];
    rand_bits(2, v);
    exp_b.resp = v[1:0];
    send_b_response(exp_b);
    host_read(REG_B_STATUS, d);
    check_word("b status", d, 32'h1);
    host_write(REG_B_POP, 32'h0);
    host_read(REG_DATA0, d);
    got_b = d[5:0];
    check_b("b entry", got_b, exp_b);
    check_word("b entry upper bits", d >> 6, 32'h0); // zero-extended
    host_read(REG_B_STATUS, d);
    check_word("b status after pop", d, 32'h0);
  endtask

  task automatic test_read_response();
    logic [AXI_DATA_W-1:0]  v;
    logic [HOST_DATA_W-1:0] d;
    logic [159:0]           words;
    r_entry_t               exp_r;
    r_entry_t               got_r;
    rand_bits(128, v);
    exp_r.data = v;
    rand_bits(4, v);
    exp_r.id = v[3:0];
    rand_bits(2, v);
    exp_r.resp = v[1:0];
    send_r_response(exp_r);
    host_read(REG_R_STATUS, d);
    check_word("r status", d, 32'h1);
    host_write(REG_R_POP, 32'h0);
    for (int i = 0; i < 5; i++) begin
      host_read(host_reg_e'(HOST_ADDR_W'(4 * i)), d);
      words[32*i +: 32] = d;
    end
    got_r = words[133:0];
    check_r("r entry", got_r, exp_r);
    check_word("r entry upper bits", 32'(words[159:134]), 32'h0);
    host_read(REG_R_STATUS, d);
    check_word("r status after pop", d, 32'h0);
  endtask

  task automatic test_far_reset();
    check_bit("far_rstn", far_rstn, 1'b1);
    host_write(REG_FAR_RST_ON, 32'h0);
    #5;
    check_bit("far_rstn on", far_rstn, 1'b0);
    host_write(REG_FAR_RST_OFF, 32'h0);
    #5;
    check_bit("far_rstn off", far_rstn, 1'b1);
  endtask

  initial begin
    rstn      = 1'b0;
    host_en   = 1'b0;
    host_we   = 4'h0;
    host_addr = REG_DATA0;
    host_din  = '0;
    awready   = 1'b1;
    wready    = 1'b1;
    arready   = 1'b1;
    bid       = '0;
    bresp     = '0;
    bvalid    = 1'b0;
    rdata     = '0;
    rid       = '0;
    rresp     = '0;
    rvalid    = 1'b0;
    repeat (3) @(posedge clk);
    #10;
    rstn = 1'b1;
    check_reset_state();

    test_stage_readback();
    test_write_request();
    test_read_backpressure();
    test_write_response();
    test_read_response();
    test_far_reset();

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+include
src/bridge_pkg.sv
src/stage_if.sv
src/sync_fifo.sv
src/host_regs.sv
src/channel_queues.sv
src/host_axi_bridge.sv
sim/tb_host_axi_bridge.sv

/* Bender.yml */
package:
  name: host_axi_bridge

sources:
  - files:
      - src/bridge_pkg.sv
      - src/stage_if.sv
      - src/sync_fifo.sv
      - src/host_regs.sv
      - src/channel_queues.sv
      - src/host_axi_bridge.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_host_axi_bridge.sv
